//--- hw/tlb_walk_params.svh
`ifndef TLB_WALK_PARAMS_SVH
`define TLB_WALK_PARAMS_SVH

// array geometry
`define TLB_SETS 512
`define TLB_WAYS 2
`define LINE_WORDS 8

// memory bus
`define BUS_DATA_WIDTH 64
`define BUS_TAG_WIDTH 13
`define BUS_TAG_LINE_RD 13'h1101 // line read request

// page table entries
`define PPN_WIDTH 54
`define PTE_PPN_LSB 10 // ppn lives in pte[63:10]

// addr_available codes
`define TLB_IDLE 2'd0
`define TLB_WAIT 2'd1
`define TLB_HIT 2'd2
`define TLB_MISS 2'd3

`endif

//--- hw/tlb_pkg.sv
package tlb_pkg;

	// one virtual address word, seen by the lookup or by the walker
	typedef union packed {
		struct packed {
			logic [15:0] unused;
			logic [23:0] tag; // va[47:24]
			logic [8:0] index; // va[23:15]
			logic [2:0] slot; // entry within the line
			logic [11:0] page_off;
		} lookup;
		struct packed {
			logic [15:0] unused;
			logic [8:0] vpn3;
			logic [8:0] vpn2;
			logic [8:0] vpn1;
			logic [8:0] vpn0;
			logic [11:0] page_off;
		} walk;
	} vaddr_u;

endpackage

//--- hw/tlb_array.sv
`timescale 1ns/100ps
`include "tlb_walk_params.svh"

module tlb_array (
	input logic clk,
	input logic reset,
	input logic [8:0] index,
	input logic flush,
	input logic touch_en,
	input logic touch_way,
	input logic fill_en,
	input logic fill_way,
	input logic [23:0] fill_tag,
	input logic [`LINE_WORDS*`BUS_DATA_WIDTH-1:0] fill_ppns,
	output logic [23:0] tag0,
	output logic [23:0] tag1,
	output logic valid0,
	output logic valid1,
	output logic lru_way,
	output logic [`LINE_WORDS*`BUS_DATA_WIDTH-1:0] ppns0,
	output logic [`LINE_WORDS*`BUS_DATA_WIDTH-1:0] ppns1
);

	logic [23:0] tag_mem [`TLB_WAYS][`TLB_SETS];
	logic [`PPN_WIDTH-1:0] ppn_mem [`TLB_WAYS][`TLB_SETS][`LINE_WORDS];
	logic [`TLB_SETS-1:0] valid [`TLB_WAYS];
	logic [`TLB_SETS-1:0] lru; // names the victim way of each set

	logic [`LINE_WORDS*`BUS_DATA_WIDTH-1:0] rd_ppns [`TLB_WAYS];

	// payload write on fill
	always_ff @(posedge clk) begin
		if (fill_en) begin
			tag_mem[fill_way][index] <= fill_tag;
			for (int w = 0; w < `LINE_WORDS; w++) begin
				ppn_mem[fill_way][index][w] <= fill_ppns[w*`BUS_DATA_WIDTH +: `PPN_WIDTH];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int w = 0; w < `TLB_WAYS; w++) begin
				valid[w] <= '0;
			end
			lru <= '0;
		end else begin
			if (flush) begin
				for (int w = 0; w < `TLB_WAYS; w++) begin
					valid[w] <= '0;
				end
			end
			// a fill during a flush still lands
			if (fill_en) begin
				valid[fill_way][index] <= 1'b1;
				lru[index] <= ~fill_way;
			end else if (touch_en) begin
				lru[index] <= ~touch_way;
			end
		end
	end

	// ppns zero extended into 64-bit lanes
	for (genvar g = 0; g < `TLB_WAYS; g++) begin : g_rd
		always_comb begin
			for (int w = 0; w < `LINE_WORDS; w++) begin
				rd_ppns[g][w*`BUS_DATA_WIDTH +: `BUS_DATA_WIDTH] =
					`BUS_DATA_WIDTH'(ppn_mem[g][index][w]);
			end
		end
	end

	assign tag0 = tag_mem[0][index];
	assign tag1 = tag_mem[1][index];
	assign valid0 = valid[0][index];
	assign valid1 = valid[1][index];
	assign lru_way = lru[index];
	assign ppns0 = rd_ppns[0];
	assign ppns1 = rd_ppns[1];

endmodule

//--- hw/page_walker.sv
`timescale 1ns/100ps
`include "tlb_walk_params.svh"

module page_walker (
	input logic clk,
	input logic reset,
	input logic walk_start,
	input logic [63:0] v_addr,
	input logic [63:0] ptbr,
	input logic abtr_grant,
	input logic bus_reqack,
	input logic bus_respcyc,
	input logic [`BUS_DATA_WIDTH-1:0] bus_resp,
	input logic [`BUS_TAG_WIDTH-1:0] bus_resptag,
	output logic abtr_reqcyc,
	output logic bus_busy,
	output logic bus_reqcyc,
	output logic [`BUS_DATA_WIDTH-1:0] bus_req,
	output logic [`BUS_TAG_WIDTH-1:0] bus_reqtag,
	output logic bus_respack,
	output logic walk_ready,
	output logic [`LINE_WORDS*`BUS_DATA_WIDTH-1:0] line_ppns
);

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_GRANT = 2'd1;
	localparam logic [1:0] S_REQ = 2'd2;
	localparam logic [1:0] S_BEATS = 2'd3;

	logic [1:0] state;
	logic [1:0] level; // 3 is the root table
	logic [2:0] beat_cnt;
	tlb_pkg::vaddr_u va_q;
	logic [`PPN_WIDTH-1:0] base; // current table page number
	logic [8:0] vpn_sel;
	logic [`LINE_WORDS*`BUS_DATA_WIDTH-1:0] line_buf;

	always_comb begin
		case (level)
			2'd3: vpn_sel = va_q.walk.vpn3;
			2'd2: vpn_sel = va_q.walk.vpn2;
			2'd1: vpn_sel = va_q.walk.vpn1;
			default: vpn_sel = va_q.walk.vpn0;
		endcase
	end

	assign abtr_reqcyc = (state == S_GRANT);
	assign bus_reqcyc = (state == S_REQ);
	// aligned 64-byte line holding entry vpn_sel
	assign bus_req = (`BUS_DATA_WIDTH'(base) << 12) +
		`BUS_DATA_WIDTH'({vpn_sel[8:3], 6'b0});
	assign bus_reqtag = `BUS_TAG_LINE_RD;
	assign bus_respack = (state == S_BEATS) && bus_respcyc &&
		(bus_resptag == `BUS_TAG_LINE_RD);
	assign line_ppns = line_buf;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			level <= 2'd0;
			beat_cnt <= 3'd0;
			bus_busy <= 1'b0;
			walk_ready <= 1'b0;
		end else begin
			walk_ready <= 1'b0;
			if (walk_ready) begin
				bus_busy <= 1'b0; // released the cycle after ready
			end
			case (state)
				S_IDLE: begin
					if (walk_start) begin
						state <= S_GRANT;
						level <= 2'd3;
					end
				end
				S_GRANT: begin
					if (abtr_grant) begin
						state <= S_REQ;
						bus_busy <= 1'b1;
					end
				end
				S_REQ: begin
					if (bus_reqack) begin
						state <= S_BEATS;
						beat_cnt <= 3'd0;
					end
				end
				default: begin
					if (bus_respack) begin
						beat_cnt <= beat_cnt + 3'd1;
						if (beat_cnt == 3'd7) begin
							if (level == 2'd0) begin
								state <= S_IDLE;
								walk_ready <= 1'b1;
							end else begin
								level <= level - 2'd1;
								state <= S_REQ; // bus still owned
							end
						end
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_IDLE && walk_start) begin
			va_q <= v_addr;
			base <= `PPN_WIDTH'(ptbr[63:12]);
		end
		if (bus_respack) begin
			if (level != 2'd0 && beat_cnt == vpn_sel[2:0]) begin
				base <= bus_resp[63:`PTE_PPN_LSB]; // next level table
			end
			if (level == 2'd0) begin
				line_buf[beat_cnt*`BUS_DATA_WIDTH +: `BUS_DATA_WIDTH] <=
					`BUS_DATA_WIDTH'(bus_resp[63:`PTE_PPN_LSB]);
			end
		end
	end

endmodule

//--- hw/tlb.sv
`timescale 1ns/100ps
`include "tlb_walk_params.svh"

module tlb (
	input logic clk,
	input logic reset,
	input logic rd_signal,
	input logic [63:0] v_addr,
	input logic [63:0] ptbr,
	input logic flush,
	input logic bus_respcyc,
	input logic bus_reqack,
	input logic [`BUS_DATA_WIDTH-1:0] bus_resp,
	input logic [`BUS_TAG_WIDTH-1:0] bus_resptag,
	input logic va_pa_abtr_grant,
	output logic [63:0] p_addr,
	output logic [1:0] addr_available,
	output logic bus_reqcyc,
	output logic bus_respack,
	output logic [`BUS_DATA_WIDTH-1:0] bus_req,
	output logic [`BUS_TAG_WIDTH-1:0] bus_reqtag,
	output logic va_pa_abtr_reqcyc,
	output logic va_pa_bus_busy
);

	tlb_pkg::vaddr_u va;

	logic [23:0] tag0;
	logic [23:0] tag1;
	logic valid0;
	logic valid1;
	logic lru_way;
	logic [`LINE_WORDS*`BUS_DATA_WIDTH-1:0] ppns0;
	logic [`LINE_WORDS*`BUS_DATA_WIDTH-1:0] ppns1;
	logic [`LINE_WORDS*`BUS_DATA_WIDTH-1:0] hit_ppns;
	logic [`BUS_DATA_WIDTH-1:0] hit_lane;

	logic hit0;
	logic hit1;
	logic hit;
	logic waiting; // miss in flight
	logic victim_way;
	logic walk_start;
	logic walk_ready;
	logic [`LINE_WORDS*`BUS_DATA_WIDTH-1:0] line_ppns;

	assign va = v_addr;

	assign hit0 = valid0 && (tag0 == va.lookup.tag);
	assign hit1 = valid1 && (tag1 == va.lookup.tag);
	assign hit = hit0 || hit1;

	assign hit_ppns = hit1 ? ppns1 : ppns0;
	assign hit_lane = hit_ppns[va.lookup.slot*`BUS_DATA_WIDTH +: `BUS_DATA_WIDTH];

	always_comb begin
		p_addr = '0;
		if (!rd_signal) begin
			addr_available = `TLB_IDLE;
		end else if (waiting) begin
			addr_available = `TLB_WAIT;
		end else if (hit) begin
			addr_available = `TLB_HIT;
			p_addr = (hit_lane << 12) + {52'b0, va.lookup.page_off};
		end else begin
			addr_available = `TLB_MISS;
		end
	end

	// first miss cycle only, waiting blocks a second start
	assign walk_start = rd_signal && !waiting && !hit;

	always_ff @(posedge clk) begin
		if (reset) begin
			waiting <= 1'b0;
		end else if (walk_ready) begin
			waiting <= 1'b0;
		end else if (walk_start) begin
			waiting <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (walk_start) begin
			victim_way <= lru_way;
		end
	end

	tlb_array u_array (
		.clk(clk),
		.reset(reset),
		.index(va.lookup.index),
		.flush(flush),
		.touch_en(rd_signal && !waiting && hit),
		.touch_way(hit1),
		.fill_en(walk_ready),
		.fill_way(victim_way),
		.fill_tag(va.lookup.tag), // requester still holds v_addr
		.fill_ppns(line_ppns),
		.tag0(tag0),
		.tag1(tag1),
		.valid0(valid0),
		.valid1(valid1),
		.lru_way(lru_way),
		.ppns0(ppns0),
		.ppns1(ppns1)
	);

	page_walker u_walker (
		.clk(clk),
		.reset(reset),
		.walk_start(walk_start),
		.v_addr(v_addr),
		.ptbr(ptbr),
		.abtr_grant(va_pa_abtr_grant),
		.bus_reqack(bus_reqack),
		.bus_respcyc(bus_respcyc),
		.bus_resp(bus_resp),
		.bus_resptag(bus_resptag),
		.abtr_reqcyc(va_pa_abtr_reqcyc),
		.bus_busy(va_pa_bus_busy),
		.bus_reqcyc(bus_reqcyc),
		.bus_req(bus_req),
		.bus_reqtag(bus_reqtag),
		.bus_respack(bus_respack),
		.walk_ready(walk_ready),
		.line_ppns(line_ppns)
	);

endmodule

//--- tb/mem_model.sv
`timescale 1ns/100ps
`include "tlb_walk_params.svh"

module mem_model (
	input logic clk,
	input logic reset,
	input logic abtr_reqcyc,
	output logic abtr_grant,
	input logic bus_reqcyc,
	input logic [`BUS_DATA_WIDTH-1:0] bus_req,
	input logic [`BUS_TAG_WIDTH-1:0] bus_reqtag,
	output logic bus_reqack,
	output logic bus_respcyc,
	output logic [`BUS_DATA_WIDTH-1:0] bus_resp,
	output logic [`BUS_TAG_WIDTH-1:0] bus_resptag
);

	localparam logic [35:0] LEAF_XOR = 36'h5a5a5a5a5;

	logic grant_q = 1'b0;
	logic ack_q = 1'b0;
	logic resp_q = 1'b0;
	logic [`BUS_DATA_WIDTH-1:0] data_q = '0;
	logic [`BUS_TAG_WIDTH-1:0] tag_q = '0;
	logic [63:0] line_addr;
	logic [`BUS_TAG_WIDTH-1:0] line_tag;
	logic beats_on = 1'b0;
	int grant_wait;
	int ack_wait;
	int gap;
	int beat;

	assign abtr_grant = grant_q;
	assign bus_reqack = ack_q;
	assign bus_respcyc = resp_q;
	assign bus_resp = data_q;
	assign bus_resptag = tag_q;

	// level code in page bits 43:40, vpn fields gathered below it
	function automatic logic [63:0] pte_word(input logic [63:0] addr);
		tlb_pkg::vaddr_u leaf_va;
		logic [51:0] page;
		logic [3:0] code;
		logic [35:0] gathered;
		logic [53:0] next_ppn;
		page = addr[63:12];
		code = page[43:40];
		gathered = {page[26:0], addr[11:3]};
		if (code == 4'd0) begin
			leaf_va = '0;
			leaf_va.walk.vpn3 = gathered[35:27];
			leaf_va.walk.vpn2 = gathered[26:18];
			leaf_va.walk.vpn1 = gathered[17:9];
			leaf_va.walk.vpn0 = gathered[8:0];
			next_ppn = 54'(leaf_va[47:12] ^ LEAF_XOR);
		end else begin
			next_ppn = {10'b0, code - 4'd1, 4'b0, gathered};
		end
		return {next_ppn, 10'b0};
	endfunction

	always @(posedge clk) begin
		if (reset) begin
			grant_q <= 1'b0;
			ack_q <= 1'b0;
			resp_q <= 1'b0;
			beats_on <= 1'b0;
			grant_wait <= $urandom_range(5);
			ack_wait <= $urandom_range(5);
		end else begin
			if (grant_q) begin
				grant_q <= 1'b0;
			end else if (abtr_reqcyc) begin
				if (grant_wait == 0) begin
					grant_q <= 1'b1;
					grant_wait <= $urandom_range(5);
				end else begin
					grant_wait <= grant_wait - 1;
				end
			end
			if (ack_q) begin
				ack_q <= 1'b0;
				beats_on <= 1'b1;
				beat <= 0;
				gap <= $urandom_range(2);
			end else if (bus_reqcyc && !beats_on) begin
				if (ack_wait == 0) begin
					ack_q <= 1'b1;
					line_addr <= bus_req;
					line_tag <= bus_reqtag;
					ack_wait <= $urandom_range(5);
				end else begin
					ack_wait <= ack_wait - 1;
				end
			end
			resp_q <= 1'b0;
			if (beats_on) begin
				if (gap > 0) begin
					gap <= gap - 1; // idle cycle between beats
				end else begin
					resp_q <= 1'b1;
					data_q <= pte_word(line_addr + 64'(beat * 8));
					tag_q <= line_tag;
					gap <= $urandom_range(2);
					if (beat == 7) begin
						beats_on <= 1'b0;
					end else begin
						beat <= beat + 1;
					end
				end
			end
		end
	end

endmodule

//--- tb/tlb_sva.sv
`timescale 1ns/100ps
`include "tlb_walk_params.svh"

module tlb_sva (
	input logic clk,
	input logic reset,
	input logic bus_reqcyc,
	input logic bus_reqack,
	input logic [`BUS_DATA_WIDTH-1:0] bus_req,
	input logic [`BUS_TAG_WIDTH-1:0] bus_reqtag,
	input logic bus_busy,
	input logic bus_respcyc,
	input logic bus_respack
);

	// request held until memory takes it
	a_req_hold: assert property (@(posedge clk) disable iff (reset)
		bus_reqcyc && !bus_reqack |=>
			bus_reqcyc && $stable(bus_req) && $stable(bus_reqtag))
		else $error("bus request dropped or changed before reqack");

	a_req_owned: assert property (@(posedge clk) disable iff (reset)
		bus_reqcyc |-> bus_busy)
		else $error("bus request while the bus is not owned");

	// every beat acked in its own cycle, never without one
	a_respack: assert property (@(posedge clk) disable iff (reset)
		bus_respack == bus_respcyc)
		else $error("respack does not match the response beat");

endmodule

bind page_walker tlb_sva u_sva (
	.clk(clk),
	.reset(reset),
	.bus_reqcyc(bus_reqcyc),
	.bus_reqack(bus_reqack),
	.bus_req(bus_req),
	.bus_reqtag(bus_reqtag),
	.bus_busy(bus_busy),
	.bus_respcyc(bus_respcyc),
	.bus_respack(bus_respack)
);

//--- tb/tb_tlb.sv
`timescale 1ns/100ps
`include "tlb_walk_params.svh"

module tb_tlb;

	localparam logic [63:0] PTBR = 64'h0030_0000_0000_0000; // root page has level code 3
	localparam logic [35:0] LEAF_XOR = 36'h5a5a5a5a5;
	localparam int WAIT_LIMIT = 400;

	logic clk = 1'b0;
	logic reset;
	logic rd_signal;
	logic [63:0] v_addr;
	logic [63:0] ptbr;
	logic flush;
	logic [63:0] p_addr;
	logic [1:0] addr_available;
	logic bus_reqcyc;
	logic bus_reqack;
	logic bus_respcyc;
	logic bus_respack;
	logic [`BUS_DATA_WIDTH-1:0] bus_req;
	logic [`BUS_DATA_WIDTH-1:0] bus_resp;
	logic [`BUS_TAG_WIDTH-1:0] bus_reqtag;
	logic [`BUS_TAG_WIDTH-1:0] bus_resptag;
	logic abtr_reqcyc;
	logic abtr_grant;
	logic bus_busy;

	// stimulus table
	logic [63:0] row_va [$];
	bit row_flush [$];
	bit row_miss [$];
	logic [63:0] row_pa [$];

	int error_count = 0;
	int check_count = 0;
	int req_total = 0;
	int grant_total = 0;
	int ungranted = 0;
	bit timed_out = 1'b0;

	always #5 clk = ~clk;

	tlb DUT (
		.clk(clk),
		.reset(reset),
		.rd_signal(rd_signal),
		.v_addr(v_addr),
		.ptbr(ptbr),
		.flush(flush),
		.bus_respcyc(bus_respcyc),
		.bus_reqack(bus_reqack),
		.bus_resp(bus_resp),
		.bus_resptag(bus_resptag),
		.va_pa_abtr_grant(abtr_grant),
		.p_addr(p_addr),
		.addr_available(addr_available),
		.bus_reqcyc(bus_reqcyc),
		.bus_respack(bus_respack),
		.bus_req(bus_req),
		.bus_reqtag(bus_reqtag),
		.va_pa_abtr_reqcyc(abtr_reqcyc),
		.va_pa_bus_busy(bus_busy)
	);

	mem_model u_mem (
		.clk(clk),
		.reset(reset),
		.abtr_reqcyc(abtr_reqcyc),
		.abtr_grant(abtr_grant),
		.bus_reqcyc(bus_reqcyc),
		.bus_req(bus_req),
		.bus_reqtag(bus_reqtag),
		.bus_reqack(bus_reqack),
		.bus_respcyc(bus_respcyc),
		.bus_resp(bus_resp),
		.bus_resptag(bus_resptag)
	);

	function automatic logic [63:0] compose_va(input logic [23:0] tag, input logic [8:0] index,
		input logic [2:0] slot, input logic [11:0] off);
		tlb_pkg::vaddr_u va;
		va = '0;
		va.lookup.tag = tag;
		va.lookup.index = index;
		va.lookup.slot = slot;
		va.lookup.page_off = off;
		return va;
	endfunction

	// leaf page number is the vpn xor a constant
	function automatic logic [63:0] expected_pa(input logic [63:0] addr);
		tlb_pkg::vaddr_u va;
		logic [35:0] vpn;
		va = addr;
		vpn = {va.walk.vpn3, va.walk.vpn2, va.walk.vpn1, va.walk.vpn0};
		return (64'(vpn ^ LEAF_XOR) << 12) + 64'(va.walk.page_off);
	endfunction

	task automatic check(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("Fail at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, actual,
				expected);
		end
	endtask

	task automatic add_row(input logic [63:0] va, input bit flush_first, input bit miss);
		row_va.push_back(va);
		row_flush.push_back(flush_first);
		row_miss.push_back(miss);
		row_pa.push_back(expected_pa(va));
	endtask

	task automatic build_table();
		logic [63:0] va;
		va = compose_va(24'h12_3456, 9'h0a5, 3'd2, 12'h1c4);
		add_row(va, 1'b0, 1'b1); // cold miss
		for (int s = 0; s < 8; s++) begin
			if (s != 2) begin
				add_row(compose_va(24'h12_3456, 9'h0a5, 3'(s), 12'(s * 12'h1f3)), 1'b0, 1'b0);
			end
		end
		add_row(compose_va(24'ha0_0001, 9'h1f0, 3'd1, 12'h010), 1'b0, 1'b1); // A to way 0
		add_row(compose_va(24'hb0_0002, 9'h1f0, 3'd4, 12'h020), 1'b0, 1'b1); // B to way 1
		add_row(compose_va(24'ha0_0001, 9'h1f0, 3'd5, 12'h030), 1'b0, 1'b0);
		add_row(compose_va(24'hc0_0003, 9'h1f0, 3'd6, 12'h040), 1'b0, 1'b1); // evicts B
		add_row(compose_va(24'ha0_0001, 9'h1f0, 3'd7, 12'h050), 1'b0, 1'b0);
		add_row(compose_va(24'hb0_0002, 9'h1f0, 3'd0, 12'h060), 1'b0, 1'b1);
		add_row(compose_va(24'ha0_0001, 9'h1f0, 3'd1, 12'h070), 1'b1, 1'b1); // after flush
		add_row(va, 1'b0, 1'b1);
		add_row(va, 1'b0, 1'b0);
		for (int i = 0; i < 20; i++) begin
			va = compose_va(24'($urandom()), 9'($urandom()), 3'($urandom()), 12'($urandom()));
			add_row(va, 1'b0, 1'b1);
			add_row(va, 1'b0, 1'b0);
		end
	endtask

	task automatic run_row(input int r);
		int cycles;
		int req_start;
		int grant_start;
		if (row_flush[r]) begin
			@(posedge clk);
			flush <= 1'b1;
			@(posedge clk);
			flush <= 1'b0;
		end
		@(posedge clk);
		rd_signal <= 1'b1;
		v_addr <= row_va[r];
		req_start = req_total;
		grant_start = grant_total;
		@(negedge clk);
		check("addr_available", 64'(addr_available),
			row_miss[r] ? 64'(`TLB_MISS) : 64'(`TLB_HIT));
		cycles = 0;
		while (addr_available != `TLB_HIT && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
			if (addr_available != `TLB_HIT) begin
				check("addr_available", 64'(addr_available), 64'(`TLB_WAIT));
				check("p_addr", p_addr, 64'd0);
			end
		end
		if (addr_available != `TLB_HIT) begin
			error_count++;
			timed_out = 1'b1;
			$display("No translation for v_addr 0x%h after %0d cycles", row_va[r], WAIT_LIMIT);
		end else begin
			check("p_addr", p_addr, row_pa[r]);
			check("bus requests", 64'(req_total - req_start), row_miss[r] ? 64'd4 : 64'd0);
			check("arbiter grants", 64'(grant_total - grant_start),
				row_miss[r] ? 64'd1 : 64'd0);
		end
		@(posedge clk);
		rd_signal <= 1'b0;
		@(negedge clk);
		check("addr_available", 64'(addr_available), 64'(`TLB_IDLE));
		check("p_addr", p_addr, 64'd0);
	endtask

	// bus handshakes, checked mid cycle
	always @(negedge clk) begin
		if (!reset && abtr_grant) begin
			grant_total++;
		end
		if (!reset && bus_reqcyc) begin
			// four line reads per granted walk
			if (grant_total * 4 <= req_total) begin
				ungranted++;
				$display("Bus request at %0t ns was raised before the arbiter grant", $time);
			end
			check("bus_reqtag", 64'(bus_reqtag), 64'(`BUS_TAG_LINE_RD));
			if (bus_reqack) begin
				req_total++;
			end
		end
	end

	initial begin
		void'($urandom(32'h2b361d2b));
		reset = 1'b1;
		rd_signal = 1'b0;
		v_addr = '0;
		ptbr = PTBR;
		flush = 1'b0;
		build_table();
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check("addr_available", 64'(addr_available), 64'(`TLB_IDLE));
		check("bus_reqcyc", 64'(bus_reqcyc), 64'd0);
		check("bus_respack", 64'(bus_respack), 64'd0);
		check("va_pa_abtr_reqcyc", 64'(abtr_reqcyc), 64'd0);
		check("va_pa_bus_busy", 64'(bus_busy), 64'd0);
		for (int r = 0; r < row_va.size() && !timed_out; r++) begin
			run_row(r);
		end
		error_count += ungranted;
		$display("%0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

//--- tlb_walk.f
+incdir+hw
hw/tlb_pkg.sv
hw/tlb_array.sv
hw/page_walker.sv
hw/tlb.sv
tb/mem_model.sv
tb/tlb_sva.sv
tb/tb_tlb.sv

//--- Makefile
TOP = tb_tlb

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f tlb_walk.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	! grep -q "TB FAILED" sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
